//--- pipe_pkg.sv
// Widths, opcodes and operand selects shared by the dual-issue pipeline and its testbench.
`default_nettype none

package pipe_pkg;

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count      = 32;

    // ALU operations, slt gives 1 or 0.
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_slt = 3'd5
    } alu_op_e;

    // First operand source.
    typedef enum logic [1:0] {
        src1_rf   = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_e;

    // Second operand source.
    typedef enum logic [1:0] {
        src2_rf   = 2'd0,
        src2_imm  = 2'd1,
        src2_cntl = 2'd2,
        src2_cnth = 2'd3
    } src2_sel_e;

endpackage

`default_nettype wire

//--- issue_port.sv
// Input side of the pipeline: latches pairs over req/ack and issues slots past a busy scoreboard.
`timescale 1ns/1ps
`default_nettype none

module issue_port (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                stall,
    input  logic                                in_req,
    output logic                                in_ack,
    input  logic                                in0_en, in1_en,
    input  pipe_pkg::alu_op_e                   in0_op, in1_op,
    input  pipe_pkg::src1_sel_e                 in0_src1, in1_src1,
    input  pipe_pkg::src2_sel_e                 in0_src2, in1_src2,
    input  logic [pipe_pkg::reg_addr_width-1:0] in0_rd, in0_rj, in0_rk, in1_rd, in1_rj, in1_rk,
    input  logic [pipe_pkg::data_width-1:0]     in0_pc, in0_imm, in1_pc, in1_imm,
    input  logic                                wr_en0, wr_en1,
    input  logic [pipe_pkg::reg_addr_width-1:0] wr_addr0, wr_addr1,
    output logic                                s0_en, s1_en,
    output pipe_pkg::alu_op_e                   s0_op, s1_op,
    output pipe_pkg::src1_sel_e                 s0_src1, s1_src1,
    output pipe_pkg::src2_sel_e                 s0_src2, s1_src2,
    output logic [pipe_pkg::reg_addr_width-1:0] s0_rd, s0_rj, s0_rk, s1_rd, s1_rj, s1_rk,
    output logic [pipe_pkg::data_width-1:0]     s0_pc, s0_imm, s1_pc, s1_imm
);
    import pipe_pkg::*;

    logic                 h0_v;
    logic                 h1_v;
    logic                 accept;
    logic                 dep;
    logic [reg_count-1:0] busy;
    logic [reg_count-1:0] busy_now;
    logic [reg_count-1:0] busy_next;

    // Free when selected sources and destination are not pending.
    function automatic logic slot_free(input logic [reg_count-1:0] bv,
                                       input src1_sel_e src1,
                                       input src2_sel_e src2,
                                       input logic [reg_addr_width-1:0] rd,
                                       input logic [reg_addr_width-1:0] rj,
                                       input logic [reg_addr_width-1:0] rk);
        return !(bv[rd] || (src1 == src1_rf && bv[rj]) || (src2 == src2_rf && bv[rk]));
    endfunction

    assign accept = in_req && !in_ack && !h0_v && !h1_v;

    // Slot 1 touching slot 0's rd goes a cycle later.
    assign dep = s1_rd == s0_rd || (s1_src1 == src1_rf && s1_rj == s0_rd) ||
                 (s1_src2 == src2_rf && s1_rk == s0_rd);

    assign s0_en = h0_v && !stall && slot_free(busy_now, s0_src1, s0_src2, s0_rd, s0_rj, s0_rk);
    assign s1_en = h1_v && !stall && slot_free(busy_now, s1_src1, s1_src2, s1_rd, s1_rj, s1_rk)
                   && (!h0_v || (s0_en && !dep));

    // A write this cycle already frees its register, the read stage bypasses it.
    always_comb begin
        busy_now = busy;
        if (wr_en0) begin
            busy_now[wr_addr0] = 1'b0;
        end
        if (wr_en1) begin
            busy_now[wr_addr1] = 1'b0;
        end
        busy_next = busy_now;
        if (s0_en) begin
            busy_next[s0_rd] = 1'b1;
        end
        if (s1_en) begin
            busy_next[s1_rd] = 1'b1;
        end
        busy_next[0] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
            h0_v <= 1'b0;
            h1_v <= 1'b0;
        end else begin
            busy <= busy_next;
            if (accept) begin
                h0_v <= in0_en;
                h1_v <= in1_en;
            end else begin
                h0_v <= h0_v && !s0_en;
                h1_v <= h1_v && !s1_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ack <= 1'b0;
        end else if (accept) begin
            in_ack <= 1'b1;
        end else if (!in_req) begin
            in_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s0_op   <= in0_op;
            s0_src1 <= in0_src1;
            s0_src2 <= in0_src2;
            s0_rd   <= in0_rd;
            s0_rj   <= in0_rj;
            s0_rk   <= in0_rk;
            s0_pc   <= in0_pc;
            s0_imm  <= in0_imm;
            s1_op   <= in1_op;
            s1_src1 <= in1_src1;
            s1_src2 <= in1_src2;
            s1_rd   <= in1_rd;
            s1_rj   <= in1_rj;
            s1_rk   <= in1_rk;
            s1_pc   <= in1_pc;
            s1_imm  <= in1_imm;
        end
    end

endmodule

`default_nettype wire

//--- register_file.sv
// Register-read stage: 32-entry register file with two write ports and operand selection.
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                stall,
    input  logic                                flush,
    input  logic [63:0]                         stable_counter,
    input  logic                                s0_en, s1_en,
    input  pipe_pkg::alu_op_e                   s0_op, s1_op,
    input  pipe_pkg::src1_sel_e                 s0_src1, s1_src1,
    input  pipe_pkg::src2_sel_e                 s0_src2, s1_src2,
    input  logic [pipe_pkg::reg_addr_width-1:0] s0_rd, s0_rj, s0_rk, s1_rd, s1_rj, s1_rk,
    input  logic [pipe_pkg::data_width-1:0]     s0_pc, s0_imm, s1_pc, s1_imm,
    input  logic                                wr_en0, wr_en1,
    input  logic [pipe_pkg::reg_addr_width-1:0] wr_addr0, wr_addr1,
    input  logic [pipe_pkg::data_width-1:0]     wr_data0, wr_data1,
    output logic                                q0_en, q1_en,
    output pipe_pkg::alu_op_e                   q0_op, q1_op,
    output logic [pipe_pkg::reg_addr_width-1:0] q0_rd, q1_rd,
    output logic [pipe_pkg::data_width-1:0]     q0_pc, q0_a, q0_b, q1_pc, q1_a, q1_b
);
    import pipe_pkg::*;

    logic [data_width-1:0] regs [reg_count];

    // Same-cycle writes are bypassed, port 1 first.
    function automatic logic [data_width-1:0] read_reg(input logic [reg_addr_width-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_en1 && wr_addr1 == addr) begin
            return wr_data1;
        end else if (wr_en0 && wr_addr0 == addr) begin
            return wr_data0;
        end
        return regs[addr];
    endfunction

    function automatic logic [data_width-1:0] sel_a(input src1_sel_e sel,
                                                    input logic [reg_addr_width-1:0] rj,
                                                    input logic [data_width-1:0] pc);
        case (sel)
            src1_rf: return read_reg(rj);
            src1_pc: return pc;
            default: return '0;
        endcase
    endfunction

    function automatic logic [data_width-1:0] sel_b(input src2_sel_e sel,
                                                    input logic [reg_addr_width-1:0] rk,
                                                    input logic [data_width-1:0] imm);
        case (sel)
            src2_rf:   return read_reg(rk);
            src2_imm:  return imm;
            src2_cntl: return stable_counter[data_width-1:0];
            default:   return stable_counter[2*data_width-1:data_width];
        endcase
    endfunction

    // Port 1 wins a collision.
    always_ff @(posedge clk) begin
        if (wr_en0 && !(wr_en1 && wr_addr1 == wr_addr0)) begin
            regs[wr_addr0] <= wr_data0;
        end
        if (wr_en1) begin
            regs[wr_addr1] <= wr_data1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q0_en <= 1'b0;
            q1_en <= 1'b0;
        end else if (!stall) begin
            q0_en <= s0_en;
            q1_en <= s1_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            q0_op <= s0_op;
            q0_rd <= s0_rd;
            q0_pc <= s0_pc;
            q0_a  <= sel_a(s0_src1, s0_rj, s0_pc);
            q0_b  <= sel_b(s0_src2, s0_rk, s0_imm);
            q1_op <= s1_op;
            q1_rd <= s1_rd;
            q1_pc <= s1_pc;
            q1_a  <= sel_a(s1_src1, s1_rj, s1_pc);
            q1_b  <= sel_b(s1_src2, s1_rk, s1_imm);
        end
    end

endmodule

`default_nettype wire

//--- alu_pair.sv
// Execute stage: two single-cycle ALUs producing registered slot results.
`timescale 1ns/1ps
`default_nettype none

module alu_pair (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                stall,
    input  logic                                flush,
    input  logic                                s0_en, s1_en,
    input  pipe_pkg::alu_op_e                   s0_op, s1_op,
    input  logic [pipe_pkg::reg_addr_width-1:0] s0_rd, s1_rd,
    input  logic [pipe_pkg::data_width-1:0]     s0_pc, s0_a, s0_b, s1_pc, s1_a, s1_b,
    output logic                                q0_en, q1_en,
    output logic [pipe_pkg::reg_addr_width-1:0] q0_rd, q1_rd,
    output logic [pipe_pkg::data_width-1:0]     q0_pc, q0_res, q1_pc, q1_res
);
    import pipe_pkg::*;

    function automatic logic [data_width-1:0] alu(input alu_op_e op,
                                                  input logic [data_width-1:0] a,
                                                  input logic [data_width-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return {{(data_width-1){1'b0}}, $signed(a) < $signed(b)};
            default: return '0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q0_en <= 1'b0;
            q1_en <= 1'b0;
        end else if (!stall) begin
            q0_en <= s0_en;
            q1_en <= s1_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            q0_rd  <= s0_rd;
            q0_pc  <= s0_pc;
            q0_res <= alu(s0_op, s0_a, s0_b);
            q1_rd  <= s1_rd;
            q1_pc  <= s1_pc;
            q1_res <= alu(s1_op, s1_a, s1_b);
        end
    end

endmodule

`default_nettype wire

//--- retire_port.sv
// Output side: writes results back and reports each one over a four-phase req/ack handshake.
`timescale 1ns/1ps
`default_nettype none

module retire_port (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                s0_en, s1_en,
    input  logic [pipe_pkg::reg_addr_width-1:0] s0_rd, s1_rd,
    input  logic [pipe_pkg::data_width-1:0]     s0_pc, s0_res, s1_pc, s1_res,
    output logic                                wr_en0, wr_en1,
    output logic [pipe_pkg::reg_addr_width-1:0] wr_addr0, wr_addr1,
    output logic [pipe_pkg::data_width-1:0]     wr_data0, wr_data1,
    output logic                                stall,
    output logic                                out_req,
    input  logic                                out_ack,
    output logic                                out_slot,
    output logic [pipe_pkg::reg_addr_width-1:0] out_rd,
    output logic [pipe_pkg::data_width-1:0]     out_pc, out_data
);
    import pipe_pkg::*;

    typedef enum logic [1:0] {
        rpt_idle,
        rpt_req,
        rpt_drop
    } rpt_state_e;

    rpt_state_e                state;
    logic                      p0_v;
    logic                      p1_v;
    logic [reg_addr_width-1:0] p0_rd, p1_rd;
    logic [data_width-1:0]     p0_pc, p0_res, p1_pc, p1_res;

    assign stall = p0_v || p1_v;

    // Writes fire on the capture edge only.
    assign wr_en0   = s0_en && !stall;
    assign wr_en1   = s1_en && !stall;
    assign wr_addr0 = s0_rd;
    assign wr_addr1 = s1_rd;
    assign wr_data0 = s0_res;
    assign wr_data1 = s1_res;

    assign out_rd   = out_slot ? p1_rd : p0_rd;
    assign out_pc   = out_slot ? p1_pc : p0_pc;
    assign out_data = out_slot ? p1_res : p0_res;

    always_ff @(posedge clk) begin
        if (!stall) begin
            p0_rd  <= s0_rd;
            p0_pc  <= s0_pc;
            p0_res <= s0_res;
            p1_rd  <= s1_rd;
            p1_pc  <= s1_pc;
            p1_res <= s1_res;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= rpt_idle;
            p0_v     <= 1'b0;
            p1_v     <= 1'b0;
            out_req  <= 1'b0;
            out_slot <= 1'b0;
        end else begin
            if (!stall) begin
                p0_v <= s0_en;
                p1_v <= s1_en;
            end
            case (state)
                rpt_idle: begin
                    // Slot 0 goes first.
                    if (stall) begin
                        out_slot <= !p0_v;
                        out_req  <= 1'b1;
                        state    <= rpt_req;
                    end
                end
                rpt_req: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= rpt_drop;
                    end
                end
                default: begin
                    if (!out_ack) begin
                        p0_v  <= p0_v && out_slot;
                        p1_v  <= p1_v && !out_slot;
                        state <= rpt_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- dual_issue_pipe.sv
// Top level of the operand-read slice: wires issue, register read, ALUs and retire together.
`timescale 1ns/1ps
`default_nettype none

module dual_issue_pipe (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                flush,
    input  logic                                in_req,
    output logic                                in_ack,
    input  logic                                in0_en, in1_en,
    input  pipe_pkg::alu_op_e                   in0_op, in1_op,
    input  pipe_pkg::src1_sel_e                 in0_src1, in1_src1,
    input  pipe_pkg::src2_sel_e                 in0_src2, in1_src2,
    input  logic [pipe_pkg::reg_addr_width-1:0] in0_rd, in0_rj, in0_rk, in1_rd, in1_rj, in1_rk,
    input  logic [pipe_pkg::data_width-1:0]     in0_pc, in0_imm, in1_pc, in1_imm,
    output logic                                out_req,
    input  logic                                out_ack,
    output logic                                out_slot,
    output logic [pipe_pkg::reg_addr_width-1:0] out_rd,
    output logic [pipe_pkg::data_width-1:0]     out_pc, out_data
);
    import pipe_pkg::*;

    logic [63:0]               stable_counter;
    logic                      stall;
    logic                      wr_en0, wr_en1;
    logic [reg_addr_width-1:0] wr_addr0, wr_addr1;
    logic [data_width-1:0]     wr_data0, wr_data1;

    // Issue to register read.
    logic                      is0_en, is1_en;
    alu_op_e                   is0_op, is1_op;
    src1_sel_e                 is0_src1, is1_src1;
    src2_sel_e                 is0_src2, is1_src2;
    logic [reg_addr_width-1:0] is0_rd, is0_rj, is0_rk, is1_rd, is1_rj, is1_rk;
    logic [data_width-1:0]     is0_pc, is0_imm, is1_pc, is1_imm;

    // Register read to ALU.
    logic                      rr0_en, rr1_en;
    alu_op_e                   rr0_op, rr1_op;
    logic [reg_addr_width-1:0] rr0_rd, rr1_rd;
    logic [data_width-1:0]     rr0_pc, rr0_a, rr0_b, rr1_pc, rr1_a, rr1_b;

    // ALU to retire.
    logic                      ex0_en, ex1_en;
    logic [reg_addr_width-1:0] ex0_rd, ex1_rd;
    logic [data_width-1:0]     ex0_pc, ex0_res, ex1_pc, ex1_res;

    always_ff @(posedge clk) begin
        if (rst) begin
            stable_counter <= '0;
        end else begin
            stable_counter <= stable_counter + 64'd1;
        end
    end

    issue_port issue_port_inst (
        .clk, .rst, .flush, .stall, .in_req, .in_ack,
        .in0_en, .in0_op, .in0_src1, .in0_src2, .in0_rd, .in0_rj, .in0_rk, .in0_pc, .in0_imm,
        .in1_en, .in1_op, .in1_src1, .in1_src2, .in1_rd, .in1_rj, .in1_rk, .in1_pc, .in1_imm,
        .wr_en0, .wr_en1, .wr_addr0, .wr_addr1,
        .s0_en(is0_en), .s0_op(is0_op), .s0_src1(is0_src1), .s0_src2(is0_src2),
        .s0_rd(is0_rd), .s0_rj(is0_rj), .s0_rk(is0_rk), .s0_pc(is0_pc), .s0_imm(is0_imm),
        .s1_en(is1_en), .s1_op(is1_op), .s1_src1(is1_src1), .s1_src2(is1_src2),
        .s1_rd(is1_rd), .s1_rj(is1_rj), .s1_rk(is1_rk), .s1_pc(is1_pc), .s1_imm(is1_imm)
    );

    register_file register_file_inst (
        .clk, .rst, .stall, .flush, .stable_counter,
        .s0_en(is0_en), .s0_op(is0_op), .s0_src1(is0_src1), .s0_src2(is0_src2),
        .s0_rd(is0_rd), .s0_rj(is0_rj), .s0_rk(is0_rk), .s0_pc(is0_pc), .s0_imm(is0_imm),
        .s1_en(is1_en), .s1_op(is1_op), .s1_src1(is1_src1), .s1_src2(is1_src2),
        .s1_rd(is1_rd), .s1_rj(is1_rj), .s1_rk(is1_rk), .s1_pc(is1_pc), .s1_imm(is1_imm),
        .wr_en0, .wr_en1, .wr_addr0, .wr_addr1, .wr_data0, .wr_data1,
        .q0_en(rr0_en), .q0_op(rr0_op), .q0_rd(rr0_rd), .q0_pc(rr0_pc),
        .q0_a(rr0_a), .q0_b(rr0_b),
        .q1_en(rr1_en), .q1_op(rr1_op), .q1_rd(rr1_rd), .q1_pc(rr1_pc),
        .q1_a(rr1_a), .q1_b(rr1_b)
    );

    alu_pair alu_pair_inst (
        .clk, .rst, .stall, .flush,
        .s0_en(rr0_en), .s0_op(rr0_op), .s0_rd(rr0_rd), .s0_pc(rr0_pc),
        .s0_a(rr0_a), .s0_b(rr0_b),
        .s1_en(rr1_en), .s1_op(rr1_op), .s1_rd(rr1_rd), .s1_pc(rr1_pc),
        .s1_a(rr1_a), .s1_b(rr1_b),
        .q0_en(ex0_en), .q0_rd(ex0_rd), .q0_pc(ex0_pc), .q0_res(ex0_res),
        .q1_en(ex1_en), .q1_rd(ex1_rd), .q1_pc(ex1_pc), .q1_res(ex1_res)
    );

    retire_port retire_port_inst (
        .clk, .rst,
        .s0_en(ex0_en), .s0_rd(ex0_rd), .s0_pc(ex0_pc), .s0_res(ex0_res),
        .s1_en(ex1_en), .s1_rd(ex1_rd), .s1_pc(ex1_pc), .s1_res(ex1_res),
        .wr_en0, .wr_en1, .wr_addr0, .wr_addr1, .wr_data0, .wr_data1,
        .stall, .out_req, .out_ack, .out_slot, .out_rd, .out_pc, .out_data
    );

endmodule

`default_nettype wire

//--- tb_dual_issue_pipe.sv
// Testbench for the dual-issue pipeline; checks each reported result against an in-order model.
`timescale 1ns/1ps
`default_nettype none

module tb_dual_issue_pipe;
    import pipe_pkg::*;

    localparam int timeout_cycles = 2000;

    typedef struct packed {
        logic                      cnt;
        logic                      slot;
        logic [reg_addr_width-1:0] rd;
        logic [data_width-1:0]     pc;
        logic [data_width-1:0]     data;
    } result_t;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      flush;
    logic                      in_req;
    logic                      in_ack;
    logic                      in0_en, in1_en;
    alu_op_e                   in0_op, in1_op;
    src1_sel_e                 in0_src1, in1_src1;
    src2_sel_e                 in0_src2, in1_src2;
    logic [reg_addr_width-1:0] in0_rd, in0_rj, in0_rk, in1_rd, in1_rj, in1_rk;
    logic [data_width-1:0]     in0_pc, in0_imm, in1_pc, in1_imm;
    logic                      out_req;
    logic                      out_ack;
    logic                      out_slot;
    logic [reg_addr_width-1:0] out_rd;
    logic [data_width-1:0]     out_pc, out_data;

    // Pair being prepared for the next send.
    logic                      p_en   [2];
    alu_op_e                   p_op   [2];
    src1_sel_e                 p_src1 [2];
    src2_sel_e                 p_src2 [2];
    logic [reg_addr_width-1:0] p_rd [2], p_rj [2], p_rk [2];
    logic [data_width-1:0]     p_pc [2], p_imm [2];

    logic [data_width-1:0]     model_regs [reg_count];
    result_t                   exp_q [$];
    logic [31:0]               gen_seed = 32'h6cb6;
    logic [31:0]               sink_seed = 32'h6cb6;
    int                        check_count = 0;
    int                        error_count = 0;
    bit                        timed_out = 1'b0;
    bit                        run_done = 1'b0;
    bit                        slow_sink = 1'b0;

    dual_issue_pipe dual_issue_pipe_inst (
        .clk, .rst, .flush, .in_req, .in_ack,
        .in0_en, .in0_op, .in0_src1, .in0_src2, .in0_rd, .in0_rj, .in0_rk, .in0_pc, .in0_imm,
        .in1_en, .in1_op, .in1_src1, .in1_src2, .in1_rd, .in1_rj, .in1_rk, .in1_pc, .in1_imm,
        .out_req, .out_ack, .out_slot, .out_rd, .out_pc, .out_data
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] gen_rand();
        gen_seed = lcg(gen_seed);
        return gen_seed;
    endfunction

    // Expected ALU result from the opcode definitions.
    function automatic logic [data_width-1:0] ref_result(input alu_op_e op,
                                                         input logic [data_width-1:0] a,
                                                         input logic [data_width-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a + ~b + 1;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return (a | b) & ~(a & b);
            default: return (int'(a) < int'(b)) ? 1 : 0;
        endcase
    endfunction

    task automatic check(input string name, input logic [data_width-1:0] got,
                         input logic [data_width-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        timed_out = 1'b1;
        error_count++;
        $display("timeout at %0d ns: %s", $time, what);
    endtask

    task automatic set_slot(input int s, input alu_op_e op, input src1_sel_e src1,
                            input src2_sel_e src2, input int rd, input int rj, input int rk);
        p_en[s]   = 1'b1;
        p_op[s]   = op;
        p_src1[s] = src1;
        p_src2[s] = src2;
        p_rd[s]   = rd[4:0];
        p_rj[s]   = rj[4:0];
        p_rk[s]   = rk[4:0];
        p_pc[s]   = gen_rand();
        p_imm[s]  = gen_rand();
    endtask

    task automatic random_slot(input int s);
        logic [31:0] r;
        int          k;
        r = gen_rand();
        k = r[28:16] % 6;
        p_en[s]   = r[31:29] != 3'd0;
        p_op[s]   = alu_op_e'(k[2:0]);
        k = r[15:8] % 3;
        p_src1[s] = src1_sel_e'(k[1:0]);
        p_src2[s] = r[20] ? src2_rf : src2_imm;
        r = gen_rand();
        p_rd[s]  = r[31:27];
        p_rj[s]  = r[26:22];
        p_rk[s]  = r[21:17];
        p_pc[s]  = gen_rand();
        p_imm[s] = gen_rand();
    endtask

    // Both slots go through the model in issue order.
    task automatic predict_pair();
        result_t               e;
        logic [data_width-1:0] a;
        logic [data_width-1:0] b;
        int                    s;
        for (s = 0; s < 2; s++) begin
            if (p_en[s]) begin
                case (p_src1[s])
                    src1_rf: a = model_regs[p_rj[s]];
                    src1_pc: a = p_pc[s];
                    default: a = '0;
                endcase
                // Counter high word stays zero in a short run.
                case (p_src2[s])
                    src2_rf:  b = model_regs[p_rk[s]];
                    src2_imm: b = p_imm[s];
                    default:  b = '0;
                endcase
                e.cnt  = p_src2[s] == src2_cntl;
                e.slot = s[0];
                e.rd   = p_rd[s];
                e.pc   = p_pc[s];
                e.data = ref_result(p_op[s], a, b);
                exp_q.push_back(e);
                if (p_rd[s] != '0) begin
                    model_regs[p_rd[s]] = e.data;
                end
            end
        end
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        if (!timed_out) begin
            @(posedge clk);
            while (in_ack !== level && n < timeout_cycles) begin
                @(posedge clk);
                n++;
            end
            if (in_ack !== level) begin
                note_timeout(level ? "in_ack never rose" : "in_ack never fell");
            end
        end
    endtask

    task automatic send_pair(input bit do_flush);
        @(posedge clk);
        if (!do_flush) begin
            predict_pair();
        end
        in0_en   <= p_en[0];
        in0_op   <= p_op[0];
        in0_src1 <= p_src1[0];
        in0_src2 <= p_src2[0];
        in0_rd   <= p_rd[0];
        in0_rj   <= p_rj[0];
        in0_rk   <= p_rk[0];
        in0_pc   <= p_pc[0];
        in0_imm  <= p_imm[0];
        in1_en   <= p_en[1];
        in1_op   <= p_op[1];
        in1_src1 <= p_src1[1];
        in1_src2 <= p_src2[1];
        in1_rd   <= p_rd[1];
        in1_rj   <= p_rj[1];
        in1_rk   <= p_rk[1];
        in1_pc   <= p_pc[1];
        in1_imm  <= p_imm[1];
        in_req   <= 1'b1;
        wait_ack(1'b1);
        in_req <= 1'b0;
        if (do_flush) begin
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
        end
        wait_ack(1'b0);
    endtask

    // Idle means every expected result was seen and the output handshake is quiet.
    task automatic drain();
        int n;
        n = 0;
        if (!timed_out) begin
            @(posedge clk);
            while ((exp_q.size() != 0 || out_req || out_ack) && n < timeout_cycles) begin
                @(posedge clk);
                n++;
            end
            if (exp_q.size() != 0 || out_req || out_ack) begin
                note_timeout("expected results were never reported");
            end
            @(posedge clk);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        drain();
        $display("test %s: %0d errors", name, error_count - errors_before);
    endtask

    initial begin : sink
        int d;
        int n;
        out_ack = 1'b0;
        while (!run_done) begin
            @(posedge clk);
            if (out_req && !out_ack) begin
                sink_seed = lcg(sink_seed);
                d = slow_sink ? 8 + sink_seed[31:28] : sink_seed[31:30];
                repeat (d) @(posedge clk);
                out_ack <= 1'b1;
                n = 0;
                @(posedge clk);
                while (out_req && n < timeout_cycles) begin
                    @(posedge clk);
                    n++;
                end
                if (out_req) begin
                    note_timeout("out_req stayed high after out_ack");
                end
                out_ack <= 1'b0;
            end
        end
    end

    initial begin : compare
        result_t               e;
        logic                  req_seen;
        logic [data_width-1:0] last_cntl;
        req_seen = 1'b0;
        last_cntl = '0;
        while (!run_done) begin
            @(posedge clk);
            if (out_req === 1'b1 && !req_seen) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("unexpected result at %0d ns for register %0d", $time, out_rd);
                end else begin
                    e = exp_q.pop_front();
                    check("out_slot", out_slot, e.slot);
                    check("out_rd", out_rd, e.rd);
                    check("out_pc", out_pc, e.pc);
                    if (e.cnt) begin
                        check("counter low increase", out_data > last_cntl, 1'b1);
                        last_cntl = out_data;
                    end else begin
                        check("out_data", out_data, e.data);
                    end
                end
            end
            req_seen = out_req === 1'b1;
        end
    end

    initial begin : stimulus
        int e0;
        int i;
        rst = 1'b1;
        flush = 1'b0;
        in_req = 1'b0;
        in0_en = 1'b0;
        in1_en = 1'b0;
        in0_op = op_add;
        in1_op = op_add;
        in0_src1 = src1_rf;
        in1_src1 = src1_rf;
        in0_src2 = src2_rf;
        in1_src2 = src2_rf;
        {in0_rd, in0_rj, in0_rk, in1_rd, in1_rj, in1_rk} = '0;
        {in0_pc, in0_imm, in1_pc, in1_imm} = '0;
        for (i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Registers power up unknown, so load them all first.
        e0 = error_count;
        for (i = 1; i < reg_count; i += 2) begin
            set_slot(0, op_or, src1_zero, src2_imm, i, 0, 0);
            set_slot(1, op_add, src1_pc, src2_imm, (i + 1) % reg_count, 0, 0);
            send_pair(1'b0);
        end
        finish_test("register load", e0);

        e0 = error_count;
        for (i = 0; i < 60; i++) begin
            random_slot(0);
            random_slot(1);
            send_pair(1'b0);
        end
        finish_test("1 random opcodes", e0);

        e0 = error_count;
        for (i = 0; i < 6; i++) begin
            set_slot(0, op_add, src1_rf, src2_rf, 5, 6, 7);
            set_slot(1, op_xor, src1_rf, src2_imm, 8, 5, 0);
            send_pair(1'b0);
            set_slot(0, op_sub, src1_rf, src2_rf, 6, 5, 8);
            set_slot(1, op_slt, src1_rf, src2_rf, 7, 8, 5);
            send_pair(1'b0);
        end
        set_slot(0, op_or, src1_pc, src2_imm, 0, 0, 0);
        set_slot(1, op_add, src1_rf, src2_imm, 9, 0, 0);
        send_pair(1'b0);
        set_slot(0, op_add, src1_pc, src2_rf, 10, 0, 0);
        set_slot(1, op_or, src1_rf, src2_rf, 11, 0, 9);
        send_pair(1'b0);
        finish_test("2 dependent pairs", e0);

        e0 = error_count;
        for (i = 0; i < 4; i++) begin
            set_slot(0, op_add, src1_pc, src2_imm, 12, 0, 0);
            set_slot(1, op_sub, src1_pc, src2_imm, 12, 0, 0);
            send_pair(1'b0);
            set_slot(0, op_or, src1_rf, src2_imm, 13, 12, 0);
            set_slot(1, op_add, src1_zero, src2_rf, 14, 0, 12);
            send_pair(1'b0);
        end
        finish_test("3 same destination", e0);

        e0 = error_count;
        slow_sink = 1'b1;
        for (i = 0; i < 20; i++) begin
            random_slot(0);
            random_slot(1);
            send_pair(1'b0);
        end
        finish_test("4 slow sink", e0);
        slow_sink = 1'b0;

        e0 = error_count;
        set_slot(0, op_add, src1_zero, src2_cntl, 0, 0, 0);
        set_slot(1, op_add, src1_zero, src2_cntl, 0, 0, 0);
        send_pair(1'b0);
        set_slot(0, op_or, src1_zero, src2_cnth, 15, 0, 0);
        set_slot(1, op_add, src1_zero, src2_cntl, 0, 0, 0);
        send_pair(1'b0);
        finish_test("5 stable counter", e0);

        e0 = error_count;
        set_slot(0, op_add, src1_pc, src2_imm, 20, 0, 0);
        set_slot(1, op_xor, src1_pc, src2_imm, 21, 0, 0);
        send_pair(1'b1);
        set_slot(0, op_add, src1_rf, src2_imm, 22, 20, 0);
        set_slot(1, op_add, src1_rf, src2_rf, 23, 21, 20);
        send_pair(1'b0);
        finish_test("6 flush", e0);

        run_done = 1'b1;
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dual_issue_pipe.f
pipe_pkg.sv
issue_port.sv
register_file.sv
alu_pair.sv
retire_port.sv
dual_issue_pipe.sv
tb_dual_issue_pipe.sv
